//--- tb/switchTrace.txt
# kind 0 is an input packet: 0 port startCycle flitCount flits (hex, one flit per cycle)
# kind 1 is expected output: 1 sourcePort flitCount flits (hex, in output order)
0 2 0 3 2003 4a11 8a12
1 2 3 2003 4a11 8a12
0 0 20 2 2002 8b00
0 1 20 2 2002 8b10
0 2 20 2 2002 8b20
0 3 20 2 2002 8b30
0 4 20 2 2002 8b40
1 0 2 2002 8b00
1 1 2 2002 8b10
1 2 2 2002 8b20
1 3 2 2002 8b30
1 4 2 2002 8b40
0 1 50 4 2002 4c11 4c12 8c13
0 3 50 2 2002 8c31
1 1 2 2002 4c11
1 3 2 2002 8c31
1 1 2 4c12 8c13
0 2 80 4 2004 4d21 4d22 8d23
0 3 80 2 2002 8d31
0 4 80 2 2002 8d41
0 0 82 2 2002 8d01
1 2 4 2004 4d21 4d22 8d23
1 3 2 2002 8d31
1 4 2 2002 8d41
1 0 2 2002 8d01
0 0 110 12 200c 4e01 4e02 4e03 4e04 4e05 4e06 4e07 4e08 4e09 4e0a 8e0b
0 4 110 12 200c 4e41 4e42 4e43 4e44 4e45 4e46 4e47 4e48 4e49 4e4a 8e4b
1 0 12 200c 4e01 4e02 4e03 4e04 4e05 4e06 4e07 4e08 4e09 4e0a 8e0b
1 4 12 200c 4e41 4e42 4e43 4e44 4e45 4e46 4e47 4e48 4e49 4e4a 8e4b

//--- list.f
source/routerPkg.sv
source/queueHeadIf.sv
source/inputQueue.sv
source/packetTimer.sv
source/switchArbiter.sv
source/crossbarStage.sv
source/routerSwitch.sv
tb/routerSwitch_checker.sv
tb/routerSwitchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the routerSwitch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module routerSwitchTb -f list.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi
exit 0

//--- tb/routerSwitchTb.sv
`timescale 1ns/1ps
`default_nettype none

module routerSwitchTb
  import routerPkg::*;
();

  localparam int QueueDepth = 8;

  logic                clk;
  logic                rst;
  flitWord             inFlit [NumPorts];
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] inReady;
  flitWord             outFlit;
  logic                outValid;
  logic [NumPorts-1:0] outPort;

  logic [15:0]         portFlits [NumPorts][$];
  int                  portCycles [NumPorts][$];
  int                  sendIdx [NumPorts];
  logic [NumPorts-1:0] accepted;
  int                  expPorts [$];
  logic [15:0]         expFlits [$];
  int                  expCount;
  int                  beats;
  int                  cycle;
  int                  cycleLimit;
  int                  inputCount;
  bit                  sawFull;

  routerSwitch #(
    .QueueDepth (QueueDepth)
  ) u_routerSwitch (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
    if (actual !== expected)
      failRun($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                        $time, msg, actual, expected));
  endtask

  // Packet records expand into one flit per cycle from their start cycle
  task automatic readTrace();
    int          fd;
    int          code;
    int          kind;
    int          port;
    int          start;
    int          count;
    logic [15:0] word;
    string       header;
    fd = $fopen("tb/switchTrace.txt", "r");
    if (fd == 0)
      failRun("could not open the trace file tb/switchTrace.txt");
    else
    begin
      code = $fgets(header, fd);
      code = $fgets(header, fd);
      while ($fscanf(fd, "%d", kind) == 1)
      begin
        if (kind == 0)
        begin
          code = $fscanf(fd, "%d %d %d", port, start, count);
          if (code != 3)
            failRun("the trace file has a malformed input record");
          for (int k = 0; k < count; k++)
          begin
            code = $fscanf(fd, "%h", word);
            if (code != 1)
              failRun("the trace file is missing an input flit");
            portFlits[port].push_back(word);
            portCycles[port].push_back(start + k);
            inputCount++;
          end
        end
        else
        begin
          code = $fscanf(fd, "%d %d", port, count);
          if (code != 2)
            failRun("the trace file has a malformed expected record");
          for (int k = 0; k < count; k++)
          begin
            code = $fscanf(fd, "%h", word);
            if (code != 1)
              failRun("the trace file is missing an expected flit");
            expPorts.push_back(port);
            expFlits.push_back(word);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      cycle = cycle + 1;
      if (cycle >= cycleLimit)
        failRun($sformatf("Timeout: only %0d of %0d output flits after %0d cycles",
                          beats, expCount, cycle));
    end
  end

  // Inputs change 10 ns after the edge and acceptance is sampled on the falling edge
  initial
  begin
    forever
    begin
      @(posedge clk);
      #10;
      if (cycle > 0)
      begin
        for (int p = 0; p < NumPorts; p++)
        begin
          if (accepted[p])
            sendIdx[p]++;
          if (sendIdx[p] < portFlits[p].size() && portCycles[p][sendIdx[p]] <= cycle)
          begin
            inValid[p] = 1'b1;
            inFlit[p] = flitWord'(portFlits[p][sendIdx[p]]);
          end
          else
            inValid[p] = 1'b0;
        end
      end
      @(negedge clk);
      for (int p = 0; p < NumPorts; p++)
      begin
        accepted[p] = inValid[p] && inReady[p];
        if (inValid[p] && !inReady[p])
          sawFull = 1'b1;
      end
    end
  end

  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      if (beats < expCount)
      begin
        checkEqual(32'(outPort), 32'(1) << expPorts[beats], "outPort");
        checkEqual(32'(outFlit), 32'(expFlits[beats]), "outFlit");
      end
      beats++;  // Flits beyond the trace only raise the count
    end
  end

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    accepted = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlit[p] = '0;
      sendIdx[p] = 0;
    end
    beats = 0;
    cycle = 0;
    inputCount = 0;
    sawFull = 1'b0;
    readTrace();
    expCount = expPorts.size();
    cycleLimit = 4 * inputCount + 200;
    repeat (10) @(posedge clk);
    #10 rst = 1'b0;
    while (beats < expCount)
      @(posedge clk);
    repeat (20) @(posedge clk);  // Catch any extra output flits
    checkEqual(32'(beats), 32'(expCount), "output flit count");
    checkEqual(32'(sawFull), 32'd1, "inReady low on a full queue");
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/routerSwitch_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Grant properties of the switch arbiter
module routerSwitch_checker
  import routerPkg::*;
(
  input wire logic                clk,
  input wire logic                rst,
  input wire logic [NumPorts:0]   grant,
  input wire logic [NumPorts-1:0] req
);

  onlyOneGrant: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot: %b", grant);

  // First edge out of reset still sees the reset value
  idleAfterReset: assert property (@(posedge clk) ($past(rst) && !rst) |-> (grant == 1))
    else $error("grant is not idle after reset: %b", grant);

  for (genvar i = 0; i < NumPorts; i++)
  begin : g_port
    holdOnlyWithReq: assert property (@(posedge clk) disable iff (rst)
      (grant[i+1] && !req[i]) |=> !grant[i+1])
      else $error("port %0d kept the grant without a request", i);
  end

endmodule

bind switchArbiter routerSwitch_checker u_checker (
  .clk   (clk),
  .rst   (rst),
  .grant (grant),
  .req   (req)
);

`default_nettype wire

//--- source/routerSwitch.sv
`timescale 1ns/1ps
`default_nettype none

module routerSwitch
  import routerPkg::*;
#(
  parameter int QueueDepth = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  flitWord             inFlit [NumPorts],
  input  logic [NumPorts-1:0] inValid,
  output logic [NumPorts-1:0] inReady,
  output flitWord             outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] outPort
);

  logic [NumPorts:0] grant;

  queueHeadIf queueHead [NumPorts] ();

  for (genvar i = 0; i < NumPorts; i++)
  begin : g_queue
    inputQueue #(
      .QueueDepth (QueueDepth)
    ) u_inputQueue (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[i]),
      .inValid (inValid[i]),
      .inReady (inReady[i]),
      .head    (queueHead[i])
    );
  end

  switchArbiter u_switchArbiter (
    .clk   (clk),
    .rst   (rst),
    .ports (queueHead),
    .grant (grant)
  );

  // Pops the granted head and registers it onto the shared output
  crossbarStage u_crossbarStage (
    .clk      (clk),
    .rst      (rst),
    .ports    (queueHead),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

//--- source/crossbarStage.sv
`timescale 1ns/1ps
`default_nettype none

module crossbarStage
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  queueHeadIf.xbar            ports [NumPorts],
  input  logic [NumPorts:0]   grant,
  output flitWord             outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] outPort
);

  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] pop;
  flitWord             headFlit [NumPorts];
  flitWord             selFlit;

  assign pop = grant[NumPorts:1] & req;  // Idle bit is dropped here

  for (genvar i = 0; i < NumPorts; i++)
  begin : g_port
    assign req[i] = ports[i].req;
    assign headFlit[i] = ports[i].headFlit;
    assign ports[i].pop = pop[i];
  end

  // The AND-OR mux relies on grant being one-hot
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < NumPorts; i++)
      selFlit = flitWord'(selFlit | (headFlit[i] & {FlitWidth{grant[i+1]}}));
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outPort <= pop;
  end

endmodule

`default_nettype wire

//--- source/switchArbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Bit 0 of grant is idle, bits 1 to NumPorts select the ports in order
module switchArbiter
  import routerPkg::*;
(
  input  logic              clk,
  input  logic              rst,
  queueHeadIf.arbiter       ports [NumPorts],
  output logic [NumPorts:0] grant
);

  localparam logic [NumPorts:0] IdleGrant = (NumPorts + 1)'(1);

  logic [NumPorts-1:0]    req;
  logic [NumPorts-1:0]    isHead;
  logic [LengthWidth-1:0] headLength [NumPorts];
  logic [NumPorts-1:0]    timesUp;
  logic [NumPorts:0]      nextGrant;

  for (genvar i = 0; i < NumPorts; i++)
  begin : g_port
    assign req[i] = ports[i].req;
    assign isHead[i] = ports[i].isHead;
    assign headLength[i] = ports[i].headLength;

    // The count includes the cycle being entered, so a grant lasts at most length cycles
    packetTimer u_packetTimer (
      .clk        (clk),
      .rst        (rst),
      .isHead     (isHead[i]),
      .headLength (headLength[i]),
      .run        (nextGrant[i+1]),
      .timesUp    (timesUp[i])
    );
  end

  always_comb
  begin
    int  curPort;
    int  cand;
    logic busy;

    // From idle the search behaves as if South had the grant, so Local comes first
    curPort = NumPorts - 1;
    busy = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i+1])
      begin
        curPort = i;
        busy = 1'b1;
      end
    end

    nextGrant = IdleGrant;
    // Walking the ring backwards leaves the nearest requester as the winner
    for (int k = NumPorts; k >= 1; k--)
    begin
      cand = curPort + k;
      if (cand >= NumPorts)
        cand = cand - NumPorts;
      if (req[cand] && !(busy && k == NumPorts))  // A busy port never regrants itself here
      begin
        nextGrant = '0;
        nextGrant[cand+1] = 1'b1;
      end
    end

    if (busy && req[curPort] && !timesUp[curPort])
      nextGrant = grant;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= IdleGrant;
    else
      grant <= nextGrant;
  end

endmodule

`default_nettype wire

//--- source/packetTimer.sv
`timescale 1ns/1ps
`default_nettype none

module packetTimer
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   isHead,
  input  logic [LengthWidth-1:0] headLength,
  input  logic                   run,
  output logic                   timesUp
);

  logic [LengthWidth-1:0] packetLength;
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      packetLength <= '0;
      count <= '0;
    end
    else
    begin
      if (isHead)
        packetLength <= headLength;  // Body flits keep the last head's length
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == packetLength);

endmodule

`default_nettype wire

//--- source/inputQueue.sv
`timescale 1ns/1ps
`default_nettype none

module inputQueue
  import routerPkg::*;
#(
  parameter int QueueDepth = 8
) (
  input  logic      clk,
  input  logic      rst,
  input  flitWord   inFlit,
  input  logic      inValid,
  output logic      inReady,
  queueHeadIf.queue head
);

  localparam int PtrWidth = $clog2(QueueDepth);
  localparam logic [PtrWidth:0] FullCount = (PtrWidth + 1)'(QueueDepth);

  flitWord             mem [QueueDepth];
  flitWord             headWord;
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth:0]   fill;
  logic                push;
  logic                pull;

  assign inReady = (fill != FullCount);
  assign push = inValid && inReady;
  assign pull = head.pop && head.req;  // Never pop an empty queue

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pull)
        rdPtr <= rdPtr + 1'b1;
      if (push && !pull)
        fill <= fill + 1'b1;
      else if (pull && !push)
        fill <= fill - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  assign headWord = mem[rdPtr];

  assign head.headFlit = headWord;
  assign head.req = (fill != '0);
  assign head.headLength = headWord.payload.head.length;
  assign head.isHead = head.req && (headWord.kind == HeadFlit);

endmodule

`default_nettype wire

//--- source/queueHeadIf.sv
`timescale 1ns/1ps
`default_nettype none

// Head of one input queue as seen by the arbiter and the crossbar
interface queueHeadIf
  import routerPkg::*;
();

  flitWord                headFlit;
  logic                   req;         // Queue is not empty
  logic                   pop;
  logic [LengthWidth-1:0] headLength;  // Valid only while isHead is high
  logic                   isHead;

  modport queue (
    output headFlit,
    output req,
    output headLength,
    output isHead,
    input  pop
  );

  modport arbiter (
    input req,
    input headLength,
    input isHead
  );

  modport xbar (
    input  headFlit,
    input  req,
    output pop
  );

endinterface

`default_nettype wire

//--- source/routerPkg.sv
`default_nettype none

package routerPkg;

  // Port order is Local, North, East, West, South
  localparam int NumPorts = 5;

  localparam int FlitIdWidth = 3;
  localparam int LengthWidth = 12;
  localparam int FlitWidth = 16;
  localparam int PayloadWidth = FlitWidth - FlitIdWidth;

  // Only the head code matters in hardware since it loads the packet timer
  localparam logic [FlitIdWidth-1:0] HeadFlit = 3'd1;
  localparam logic [FlitIdWidth-1:0] BodyFlit = 3'd2;
  localparam logic [FlitIdWidth-1:0] TailFlit = 3'd4;

  typedef struct packed {
    logic                   spare;
    logic [LengthWidth-1:0] length;  // Flit count of the packet, head included
  } headFields;

  // A head flit carries the packet length while body and tail flits carry data
  typedef union packed {
    headFields               head;
    logic [PayloadWidth-1:0] data;
  } flitPayload;

  typedef struct packed {
    logic [FlitIdWidth-1:0] kind;
    flitPayload             payload;
  } flitWord;

endpackage

`default_nettype wire
